// File: common/conv2_pkg.sv
//////////////////////////////////////////////////////////////////////////////
// conv2 layer shared types
// widths and packed types for pixels, 5x5 windows, kernels and biases
//////////////////////////////////////////////////////////////////////////////

`default_nettype none

package conv2_pkg;

  localparam int PIX_W       = 12;
  localparam int WGT_W       = 8;   // weights and bias
  localparam int KSIZE       = 5;
  localparam int N_TAPS      = KSIZE * KSIZE;
  localparam int N_IN        = 3;   // input maps
  localparam int N_OUT       = 3;   // output filters
  localparam int PROD_W      = 20;  // products and sums wrap here
  localparam int SCALE_SHIFT = 7;
  localparam int TREE_LAT    = 5;

  typedef logic signed [PIX_W-1:0] pixel_t;

  // one pixel of each input map, same raster position
  typedef struct packed {
    pixel_t ch0;
    pixel_t ch1;
    pixel_t ch2;
  } pixel_vec_t;

  // tap = row * KSIZE + col, row 0 oldest
  typedef pixel_t [N_TAPS-1:0] window_t;

  typedef logic signed [WGT_W-1:0] weight_t;

  typedef weight_t [N_TAPS-1:0] kernel_t;

  // one kernel per input map
  typedef kernel_t [N_IN-1:0] filter_weights_t;

  typedef logic signed [PROD_W-1:0] prod_t;

  typedef logic signed [WGT_W-1:0] bias_t;

endpackage

`default_nettype wire

// File: filter/conv2_adder_tree.sv
//////////////////////////////////////////////////////////////////////////////
// conv2 adder tree
// five registered stages summing 25 products, odd operand passed through
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module conv2_adder_tree (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,
  input  conv2_pkg::prod_t [conv2_pkg::N_TAPS-1:0]  operands,
  output conv2_pkg::prod_t                          sum
);

  // operand count per stage: 25 13 7 4 2 1
  localparam int L0 = conv2_pkg::N_TAPS;
  localparam int L1 = (L0 + 1) / 2;
  localparam int L2 = (L1 + 1) / 2;
  localparam int L3 = (L2 + 1) / 2;
  localparam int L4 = (L3 + 1) / 2;

  conv2_pkg::prod_t [L1-1:0] lvl1;
  conv2_pkg::prod_t [L2-1:0] lvl2;
  conv2_pkg::prod_t [L3-1:0] lvl3;
  conv2_pkg::prod_t [L4-1:0] lvl4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lvl1 <= '0;
      lvl2 <= '0;
      lvl3 <= '0;
      lvl4 <= '0;
      sum  <= '0;
    end else begin
      for (int i = 0; i < L0 / 2; i++) begin
        lvl1[i] <= operands[2*i] + operands[2*i+1];
      end
      if (L0 % 2 != 0) begin
        lvl1[L1-1] <= operands[L0-1];
      end

      for (int i = 0; i < L1 / 2; i++) begin
        lvl2[i] <= lvl1[2*i] + lvl1[2*i+1];
      end
      if (L1 % 2 != 0) begin
        lvl2[L2-1] <= lvl1[L1-1];
      end

      for (int i = 0; i < L2 / 2; i++) begin
        lvl3[i] <= lvl2[2*i] + lvl2[2*i+1];
      end
      if (L2 % 2 != 0) begin
        lvl3[L3-1] <= lvl2[L2-1];
      end

      for (int i = 0; i < L3 / 2; i++) begin
        lvl4[i] <= lvl3[2*i] + lvl3[2*i+1];
      end
      if (L3 % 2 != 0) begin
        lvl4[L4-1] <= lvl3[L3-1];
      end

      sum <= lvl4[0] + lvl4[1];  // wraps at PROD_W
    end
  end

endmodule

`default_nettype wire

// File: filter/conv2_filter.sv
//////////////////////////////////////////////////////////////////////////////
// conv2 output filter
// multiplies three windows by their kernels, sums them, then scales and
// adds the bias
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module conv2_filter (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  conv2_pkg::window_t         windows [conv2_pkg::N_IN],
  input  wire logic                  window_valid,
  input  conv2_pkg::filter_weights_t weights,
  input  conv2_pkg::bias_t           bias,
  output conv2_pkg::pixel_t          result,
  output logic                       result_valid
);

  // multiply, tree, two channel-sum steps, output
  localparam int LAT = 1 + conv2_pkg::TREE_LAT + 2 + 1;

  conv2_pkg::prod_t [conv2_pkg::N_TAPS-1:0] prods [conv2_pkg::N_IN];
  conv2_pkg::prod_t tree_sum [conv2_pkg::N_IN];

  conv2_pkg::prod_t sum01;
  conv2_pkg::prod_t sum2_d;
  conv2_pkg::prod_t total;

  logic [LAT-1:0] valid_sr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < conv2_pkg::N_IN; c++) begin
        prods[c] <= '0;
      end
    end else begin
      for (int c = 0; c < conv2_pkg::N_IN; c++) begin
        for (int t = 0; t < conv2_pkg::N_TAPS; t++) begin
          if (window_valid) begin
            prods[c][t] <= windows[c][t] * weights[c][t];  // 12x8 signed
          end else begin
            prods[c][t] <= '0;
          end
        end
      end
    end
  end

  for (genvar c = 0; c < conv2_pkg::N_IN; c++) begin : g_tree
    conv2_adder_tree tree_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .operands(prods[c]),
      .sum     (tree_sum[c])
    );
  end

  // channel sum in two steps, then scale and bias
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum01  <= '0;
      sum2_d <= '0;
      total  <= '0;
      result <= '0;
    end else begin
      sum01  <= tree_sum[0] + tree_sum[1];
      sum2_d <= tree_sum[2];
      total  <= sum01 + sum2_d;
      // floor shift, then 12-bit wrap with the sign-extended bias
      result <= conv2_pkg::pixel_t'(total >>> conv2_pkg::SCALE_SHIFT)
              + conv2_pkg::pixel_t'(bias);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[LAT-2:0], window_valid};
    end
  end

  assign result_valid = valid_sr[LAT-1];

endmodule

`default_nettype wire

// File: window/conv2_window_buf.sv
//////////////////////////////////////////////////////////////////////////////
// conv2 window buffer
// five-row circular line buffer, emits one 5x5 window per valid position
// with the oldest row first
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module conv2_window_buf #(
  parameter int IMG_W = 12,
  parameter int IMG_H = 12
) (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  conv2_pkg::pixel_t  pixel,
  input  wire logic          pixel_valid,
  output conv2_pkg::window_t window,
  output logic               window_valid
);

  localparam int K         = conv2_pkg::KSIZE;
  localparam int COL_W     = $clog2(IMG_W);
  localparam int ROW_W     = $clog2(IMG_H);
  localparam int ROW_IDX_W = $clog2(K);

  conv2_pkg::pixel_t mem [K][IMG_W];  // circular row store

  logic [COL_W-1:0]     col;
  logic [ROW_W-1:0]     row;
  logic [ROW_IDX_W-1:0] top_row;      // slot of the oldest window row
  logic [ROW_IDX_W-1:0] slot [K];     // physical slot of window row k
  logic                 win_hit;

  // window row k lives in slot (top_row + k) mod K
  always_comb begin
    for (int k = 0; k < K; k++) begin
      if (top_row + k >= K) begin
        slot[k] = ROW_IDX_W'(top_row + k - K);
      end else begin
        slot[k] = ROW_IDX_W'(top_row + k);
      end
    end
  end

  assign win_hit = pixel_valid && (col >= K - 1) && (row >= K - 1);

  // newest row always goes to the last slot
  always_ff @(posedge clk) begin
    if (pixel_valid) begin
      mem[slot[K-1]][col] <= pixel;
    end
  end

  // raster position
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col     <= '0;
      row     <= '0;
      top_row <= '0;
    end else if (pixel_valid) begin
      if (col == COL_W'(IMG_W - 1)) begin
        col <= '0;
        if (top_row == ROW_IDX_W'(K - 1)) begin
          top_row <= '0;
        end else begin
          top_row <= top_row + 1'b1;
        end
        if (row == ROW_W'(IMG_H - 1)) begin
          row <= '0;  // next pixel starts a frame
        end else begin
          row <= row + 1'b1;
        end
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // gather the 25 taps
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      window       <= '0;
      window_valid <= 1'b0;
    end else begin
      window_valid <= win_hit;
      if (win_hit) begin
        for (int k = 0; k < K; k++) begin
          for (int j = 0; j < K; j++) begin
            window[k*K + j] <= mem[slot[k]][col - (K - 1) + j];
          end
        end
        // current pixel is not in memory yet
        window[conv2_pkg::N_TAPS-1] <= pixel;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/conv2_layer.sv
//////////////////////////////////////////////////////////////////////////////
// conv2 layer top
// three 5x5 window buffers feeding three output filters
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module conv2_layer #(
  parameter int IMG_W = 12,
  parameter int IMG_H = 12
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  conv2_pkg::pixel_vec_t           pixel_in,
  input  wire logic                       pixel_valid,
  input  conv2_pkg::filter_weights_t      weights [conv2_pkg::N_OUT],
  input  conv2_pkg::bias_t                bias    [conv2_pkg::N_OUT],
  output conv2_pkg::pixel_t               result  [conv2_pkg::N_OUT],
  output logic                            result_valid
);

  conv2_pkg::pixel_t  ch_pixel [conv2_pkg::N_IN];
  conv2_pkg::window_t windows  [conv2_pkg::N_IN];

  logic [conv2_pkg::N_IN-1:0]  win_valid;
  logic [conv2_pkg::N_OUT-1:0] filt_valid;

  // unpack the per-map pixels
  assign ch_pixel[0] = pixel_in.ch0;
  assign ch_pixel[1] = pixel_in.ch1;
  assign ch_pixel[2] = pixel_in.ch2;

  for (genvar c = 0; c < conv2_pkg::N_IN; c++) begin : g_win
    conv2_window_buf #(
      .IMG_W(IMG_W),
      .IMG_H(IMG_H)
    ) win_buf_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .pixel       (ch_pixel[c]),
      .pixel_valid (pixel_valid),
      .window      (windows[c]),
      .window_valid(win_valid[c])
    );
  end

  // all buffers see the same strobe, so channel 0 stands for all
  for (genvar f = 0; f < conv2_pkg::N_OUT; f++) begin : g_filt
    conv2_filter filter_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .windows     (windows),
      .window_valid(win_valid[0]),
      .weights     (weights[f]),
      .bias        (bias[f]),
      .result      (result[f]),
      .result_valid(filt_valid[f])
    );
  end

  assign result_valid = filt_valid[0];

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////////////
// testbench clock and reset
// free-running clock, active-low reset held for a few cycles
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;  // released just after an edge
  end

endmodule

`default_nettype wire

// File: testbench/tb_conv2_layer.sv
//////////////////////////////////////////////////////////////////////////////
// conv2 layer testbench
// table of image, gap and weight setups, checked against a reference model
//////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_conv2_layer;

  localparam int IMG_W = 12;
  localparam int IMG_H = 12;
  localparam int KS    = 5;
  localparam int OUT_W = IMG_W - KS + 1;
  localparam int OUT_H = IMG_H - KS + 1;

  localparam int RESET_TIMEOUT  = 50;
  localparam int RESULT_TIMEOUT = 400;
  localparam int QUIET_CYCLES   = 20;

  localparam int IMG_CONST = 0;
  localparam int IMG_RAND  = 1;
  localparam int IMG_RAMP  = 2;
  localparam int GAP_NONE  = 0;
  localparam int GAP_ONE   = 1;
  localparam int GAP_RAND  = 2;
  localparam int WGT_CONST = 0;
  localparam int WGT_RAND  = 1;  // random weights and biases

  typedef struct packed {
    int img_kind;
    int img_val;
    int gap_kind;
    int wgt_kind;
    int wgt_val;
    int bias0;
    int bias1;
    int bias2;
    int exp0;
    int exp1;
    int exp2;
    int frames;
  } test_row_t;

  localparam int N_TESTS = 7;

  // exp columns only used by constant rows
  localparam test_row_t TESTS [N_TESTS] = '{
    '{IMG_CONST,    10, GAP_NONE, WGT_CONST,    1,  0,    5,  -3,     5,    10,     2, 1},
    '{IMG_CONST,    -7, GAP_ONE,  WGT_CONST,    3,  0, -128, 127,   -13,  -141,   114, 1},
    '{IMG_CONST,  2047, GAP_NONE, WGT_CONST,  127,  1,   -1, 100,   774,   772,   873, 1},
    '{IMG_CONST, -2048, GAP_ONE,  WGT_CONST, -128, -1,    0, 127,  2047, -2048, -1921, 1},
    '{IMG_RAND,      0, GAP_RAND, WGT_RAND,     0,  0,    0,   0,     0,     0,     0, 1},
    '{IMG_RAMP,      0, GAP_ONE,  WGT_RAND,     0,  0,    0,   0,     0,     0,     0, 1},
    '{IMG_RAND,      0, GAP_NONE, WGT_RAND,     0,  0,    0,   0,     0,     0,     0, 2}
  };

  logic clk;
  logic rst_n;

  conv2_pkg::pixel_vec_t      pixel_in;
  logic                       pixel_valid;
  conv2_pkg::filter_weights_t weights [conv2_pkg::N_OUT];
  conv2_pkg::bias_t           bias    [conv2_pkg::N_OUT];
  conv2_pkg::pixel_t          result  [conv2_pkg::N_OUT];
  logic                       result_valid;

  int          img [2][conv2_pkg::N_IN][IMG_H][IMG_W];
  logic [35:0] exp_q [$];     // {f2, f1, f0} per output position
  int          strobe_q [$];  // strobe cycle of each window-completing pixel
  logic [15:0] lfsr_state;
  int          cyc = 0;
  int          err_count = 0;
  int          check_count = 0;

  tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(3)) clk_gen_i (.clk(clk), .rst_n(rst_n));

  conv2_layer #(
    .IMG_W(IMG_W),
    .IMG_H(IMG_H)
  ) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pixel_in    (pixel_in),
    .pixel_valid (pixel_valid),
    .weights     (weights),
    .bias        (bias),
    .result      (result),
    .result_valid(result_valid)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // galois, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      err_count++;
    end
  endtask

  function automatic string kind_name(input int kind);
    case (kind)
      IMG_CONST: return "constant";
      IMG_RAND:  return "random";
      default:   return "ramp";
    endcase
  endfunction

  // 20-bit wrapping sum, floor shift, 12-bit wrap with sign-extended bias
  function automatic logic [11:0] model_pixel(input int fr, input int f,
                                               input int r0, input int c0);
    int                 acc;
    logic signed [19:0] total;
    logic signed [11:0] scaled;
    acc = 0;
    for (int c = 0; c < conv2_pkg::N_IN; c++) begin
      for (int kr = 0; kr < KS; kr++) begin
        for (int kc = 0; kc < KS; kc++) begin
          acc += img[fr][c][r0 + kr][c0 + kc] * int'(weights[f][c][kr * KS + kc]);
        end
      end
    end
    total  = acc[19:0];
    scaled = 12'(total >>> 7);
    return scaled + 12'(int'(bias[f]));
  endfunction

  task automatic make_stimulus(input test_row_t t);
    logic [31:0] v;
    for (int fr = 0; fr < t.frames; fr++) begin
      for (int ch = 0; ch < conv2_pkg::N_IN; ch++) begin
        for (int r = 0; r < IMG_H; r++) begin
          for (int c = 0; c < IMG_W; c++) begin
            if (t.img_kind == IMG_CONST) begin
              img[fr][ch][r][c] = t.img_val;
            end else if (t.img_kind == IMG_RAND) begin
              take_bits(12, v);
              img[fr][ch][r][c] = int'(conv2_pkg::pixel_t'(v[11:0]));
            end else begin
              // ramp, wraps at 12 bits
              img[fr][ch][r][c] = int'(conv2_pkg::pixel_t'((r * IMG_W + c) * 29
                                  + ch * 300 - 2000 + fr * 7));
            end
          end
        end
      end
    end
    for (int f = 0; f < conv2_pkg::N_OUT; f++) begin
      for (int c = 0; c < conv2_pkg::N_IN; c++) begin
        for (int tp = 0; tp < conv2_pkg::N_TAPS; tp++) begin
          if (t.wgt_kind == WGT_CONST) begin
            weights[f][c][tp] = conv2_pkg::weight_t'(t.wgt_val);
          end else begin
            take_bits(8, v);
            weights[f][c][tp] = v[7:0];
          end
        end
      end
      take_bits(8, v);
      bias[f] = v[7:0];
    end
    if (t.wgt_kind == WGT_CONST) begin
      bias[0] = conv2_pkg::bias_t'(t.bias0);
      bias[1] = conv2_pkg::bias_t'(t.bias1);
      bias[2] = conv2_pkg::bias_t'(t.bias2);
    end
    exp_q.delete();
    strobe_q.delete();
    for (int fr = 0; fr < t.frames; fr++) begin
      for (int r = 0; r < OUT_H; r++) begin
        for (int c = 0; c < OUT_W; c++) begin
          if (t.img_kind == IMG_CONST) begin
            exp_q.push_back({12'(t.exp2), 12'(t.exp1), 12'(t.exp0)});
          end else begin
            exp_q.push_back({model_pixel(fr, 2, r, c), model_pixel(fr, 1, r, c),
                             model_pixel(fr, 0, r, c)});
          end
        end
      end
    end
  endtask

  task automatic drive_frames(input int frames, input int gap_kind);
    logic [31:0] g;
    int          idle;
    for (int fr = 0; fr < frames; fr++) begin
      for (int r = 0; r < IMG_H; r++) begin
        for (int c = 0; c < IMG_W; c++) begin
          @(posedge clk);
          #1;
          pixel_in.ch0 = conv2_pkg::pixel_t'(img[fr][0][r][c]);
          pixel_in.ch1 = conv2_pkg::pixel_t'(img[fr][1][r][c]);
          pixel_in.ch2 = conv2_pkg::pixel_t'(img[fr][2][r][c]);
          pixel_valid  = 1'b1;
          if (r >= KS - 1 && c >= KS - 1) begin
            strobe_q.push_back(cyc);
          end
          idle = (gap_kind == GAP_ONE) ? 1 : 0;
          if (gap_kind == GAP_RAND) begin
            take_bits(2, g);
            idle = g;
          end
          repeat (idle) begin
            @(posedge clk);
            #1 pixel_valid = 1'b0;
          end
        end
      end
    end
    @(posedge clk);
    #1 pixel_valid = 1'b0;
  endtask

  task automatic collect_results(input int n_exp);
    logic [35:0] exp;
    logic        got;
    int          waited;
    int          strobe_cyc;
    got = 1'b1;
    for (int i = 0; i < n_exp && got; i++) begin
      waited = 0;
      got    = 1'b0;
      while (!got && waited < RESULT_TIMEOUT) begin
        @(negedge clk);
        waited++;
        got = result_valid;
      end
      if (!got) begin
        $display("timed out waiting for result %0d of %0d", i, n_exp);
        err_count++;
      end else begin
        if (strobe_q.size() == 0) begin
          $display("result_valid pulsed with no complete window before it");
          err_count++;
        end else begin
          strobe_cyc = strobe_q.pop_front();
          check_value("result latency", 32'(cyc - strobe_cyc), 32'd10);  // from strobe cycle
        end
        exp = exp_q.pop_front();
        for (int f = 0; f < conv2_pkg::N_OUT; f++) begin
          check_value($sformatf("result[%0d]", f), 32'($unsigned(result[f])),
                      32'(exp[f*12 +: 12]));
        end
      end
    end
    if (got) begin
      repeat (QUIET_CYCLES) begin
        @(negedge clk);
        if (result_valid) begin
          $display("result_valid pulsed after the last expected result");
          err_count++;
        end
      end
    end
  endtask

  task automatic wait_reset();
    int waited;
    waited = 0;
    while (!rst_n && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      $display("reset was not released within %0d cycles", RESET_TIMEOUT);
      err_count++;
    end
  endtask

  initial begin
    int test_errs;
    int n_res;
    lfsr_state  = 16'd61;
    pixel_in    = '0;
    pixel_valid = 1'b0;
    for (int f = 0; f < conv2_pkg::N_OUT; f++) begin
      weights[f] = '0;
      bias[f]    = '0;
    end
    wait_reset();
    for (int i = 0; i < N_TESTS; i++) begin
      test_errs = err_count;
      @(posedge clk);
      #1;
      make_stimulus(TESTS[i]);
      n_res = TESTS[i].frames * OUT_W * OUT_H;
      fork
        drive_frames(TESTS[i].frames, TESTS[i].gap_kind);
        collect_results(n_res);
      join
      $display("test %0d: %s image, %0d frame(s), %0d results, %0d errors", i,
               kind_name(TESTS[i].img_kind), TESTS[i].frames, n_res, err_count - test_errs);
    end
    $display("tests %0d, checks %0d, errors %0d", N_TESTS, check_count, err_count);
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
common/conv2_pkg.sv
filter/conv2_adder_tree.sv
filter/conv2_filter.sv
window/conv2_window_buf.sv
hdl/conv2_layer.sv
testbench/tb_clk_gen.sv
testbench/tb_conv2_layer.sv

// File: Bender.yml
package:
  name: conv2_layer

sources:
  - common/conv2_pkg.sv
  - filter/conv2_adder_tree.sv
  - filter/conv2_filter.sv
  - window/conv2_window_buf.sv
  - hdl/conv2_layer.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_conv2_layer.sv
